/* compile.f */
verilog/mips_pkg.sv
verilog/mips_regfile.sv
verilog/mips_alu.sv
verilog/mips_decode.sv
verilog/mips_core.sv
verilog/mips_ctrl_regs.sv
verilog/mips_subsys_top.sv
dv/tb_mips_subsys.sv

/* Makefile */
SIM := obj_dir/Vtb_mips_subsys
SOURCES := $(shell cat compile.f)

.PHONY: all run clean

all: run

$(SIM): compile.f $(SOURCES)
	verilator --binary --assert --top-module tb_mips_subsys -f compile.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -qx 'TEST PASS' sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/tb_mips_subsys.sv */
`timescale 1ns/1ps

module tb_mips_subsys;

    import mips_pkg::*;

    localparam int WAIT_LIMIT = 100;
    // jr $zero also fills every fetch past the loaded image
    localparam logic [31:0] JR_ZERO = {OP_RTYPE, 15'd0, 5'd0, FN_JR};
    localparam logic [4:0] R_ZERO = 5'd0;
    localparam logic [4:0] R_V0   = 5'd2;
    localparam logic [4:0] R_T0   = 5'd8;
    localparam logic [4:0] R_T1   = 5'd9;
    localparam logic [4:0] R_T2   = 5'd10;
    localparam logic [4:0] R_T3   = 5'd11;
    localparam logic [4:0] R_T4   = 5'd12;
    localparam logic [4:0] R_T5   = 5'd13;

    logic        clk = 1'b0;
    logic        rst_n;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    logic [31:0] data_address;
    logic        data_write;
    logic        data_read;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;

    // instruction memory is word indexed from the reset vector
    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] imem_offset;

    // high from reset until a program is started
    logic        fresh;
    logic [31:0] exp_store_addr;
    logic [31:0] exp_store_data;
    logic [31:0] exp_load_addr;
    int          stores = 0;
    int          loads = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;

    always #4 clk = ~clk;

    mips_subsys_top u_mips_subsys_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .axil_req       (axil_req),
        .axil_rsp       (axil_rsp),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    // combinational fetch
    assign imem_offset    = instr_address - RESET_VECTOR;
    assign instr_readdata = (imem_offset < 32'd256) ? imem[imem_offset[7:2]] : JR_ZERO;

    // combinational load and single cycle store
    assign data_readdata = dmem[data_address[7:2]];

    always @(posedge clk) begin
        if (!rst_n) begin
            // background pattern tied to each word address
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= 32'hDA7A_0000 | (32'(i) << 2);
            end
        end else if (data_write) begin
            dmem[data_address[7:2]] <= data_writedata;
        end
    end

    // every store has to match what the running program should write
    always @(posedge clk) begin
        if (rst_n && data_write) begin
            stores <= stores + 1;
            assert (data_address == exp_store_addr && data_writedata == exp_store_data) else begin
                $display("FAILED data_address 0x%h data_writedata 0x%h expected 0x%h 0x%h",
                         data_address, data_writedata, exp_store_addr, exp_store_data);
                errors++;
            end
        end
    end

    // every load has to read from the address the program computes
    always @(posedge clk) begin
        if (rst_n && data_read) begin
            loads <= loads + 1;
            assert (data_address == exp_load_addr) else begin
                $display("FAILED data_address 0x%h on a load expected 0x%h",
                         data_address, exp_load_addr);
                errors++;
            end
        end
    end

    // core parked on the reset vector until run is set
    a_idle: assert property (@(posedge clk) disable iff (!rst_n)
        fresh |-> instr_address == RESET_VECTOR && !data_write)
        else begin
            $display("FAILED instr_address 0x%h data_write 0x%h while not running",
                     instr_address, data_write);
            errors++;
        end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else begin
            $display("bvalid dropped before bready was seen");
            errors++;
        end

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
        else begin
            $display("rvalid dropped or rdata changed before rready was seen");
            errors++;
        end

    // a pending response blocks the next request of its kind
    a_write_blocked: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.bvalid |-> !axil_rsp.awready && !axil_rsp.wready)
        else begin
            $display("write accepted while a write response was pending");
            errors++;
        end

    a_read_blocked: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.rvalid |-> !axil_rsp.arready)
        else begin
            $display("read accepted while a read response was pending");
            errors++;
        end

    a_okay: assert property (@(posedge clk) disable iff (!rst_n)
        (!axil_rsp.bvalid || axil_rsp.bresp == 2'b00) &&
        (!axil_rsp.rvalid || axil_rsp.rresp == 2'b00))
        else begin
            $display("FAILED axil_rsp.bresp 0x%h axil_rsp.rresp 0x%h expected 0x0",
                     axil_rsp.bresp, axil_rsp.rresp);
            errors++;
        end

    function automatic logic [31:0] rtype(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] funct);
        return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] sext(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("timeout waiting for %s", what);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED %s 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        tests++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - errors_at_start);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n    = 1'b0;
        fresh    = 1'b1;
        axil_req = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic load_program(input logic [31:0] prog[$]);
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : JR_ZERO;
        end
    endtask

    // address and data presented together and held until both readies
    task automatic issue_write(input logic [3:0] addr, input logic [31:0] data);
        int   n;
        logic seen;
        @(negedge clk);
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hF;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < WAIT_LIMIT) begin
            @(posedge clk);
            seen = axil_rsp.awready && axil_rsp.wready;
            n++;
        end
        if (!seen) begin
            stop_on_timeout("awready and wready");
        end
        @(negedge clk);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
    endtask

    // bready held low for delay cycles first
    task automatic collect_bresp(input int delay);
        int   n;
        logic seen;
        repeat (delay) @(negedge clk);
        @(negedge clk);
        axil_req.bready = 1'b1;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < WAIT_LIMIT) begin
            @(posedge clk);
            seen = axil_rsp.bvalid;
            n++;
        end
        if (!seen) begin
            stop_on_timeout("bvalid");
        end
        @(negedge clk);
        axil_req.bready = 1'b0;
    endtask

    task automatic issue_read(input logic [3:0] addr);
        int   n;
        logic seen;
        @(negedge clk);
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < WAIT_LIMIT) begin
            @(posedge clk);
            seen = axil_rsp.arready;
            n++;
        end
        if (!seen) begin
            stop_on_timeout("arready");
        end
        @(negedge clk);
        axil_req.arvalid = 1'b0;
    endtask

    task automatic collect_rdata(input int delay, output logic [31:0] data);
        int   n;
        logic seen;
        repeat (delay) @(negedge clk);
        @(negedge clk);
        axil_req.rready = 1'b1;
        n    = 0;
        seen = 1'b0;
        data = '0;
        while (!seen && n < WAIT_LIMIT) begin
            @(posedge clk);
            seen = axil_rsp.rvalid;
            data = axil_rsp.rdata;
            n++;
        end
        if (!seen) begin
            stop_on_timeout("rvalid");
        end
        @(negedge clk);
        axil_req.rready = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        issue_write(addr, data);
        collect_bresp($urandom % 4);
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
        issue_read(addr);
        collect_rdata($urandom % 4, data);
    endtask

    // STATUS bit 0 follows the core's active flag
    task automatic wait_for_halt();
        logic [31:0] status;
        int          n;
        n      = 0;
        status = 32'd1;
        while (status[0] && n < WAIT_LIMIT) begin
            read_reg(REG_STATUS, status);
            n++;
        end
        if (status[0]) begin
            stop_on_timeout("the core to halt");
        end
    endtask

    // run bit plus a RETIRED clear and then wait for jr $zero
    task automatic run_program(input logic [31:0] prog[$]);
        load_program(prog);
        fresh = 1'b0;
        write_reg(REG_CTRL, 32'h3);
        wait_for_halt();
    endtask

    task automatic check_idle();
        int          start;
        logic [31:0] prog[$];
        logic [31:0] d;
        start = errors;
        apply_reset();
        // a store up front that must stay gated while run is 0
        prog = {itype(OP_SW, R_ZERO, R_ZERO, 16'h0010),
                itype(OP_ADDIU, R_ZERO, R_V0, 16'h1234)};
        load_program(prog);
        @(negedge clk);
        check_value("axil_rsp handshake bits", {27'd0, axil_rsp.awready, axil_rsp.wready,
                    axil_rsp.bvalid, axil_rsp.arready, axil_rsp.rvalid}, 32'd0);
        repeat (10) @(negedge clk);
        check_value("instr_address", instr_address, RESET_VECTOR);
        check_value("data_write", {31'd0, data_write}, 32'd0);
        read_reg(REG_V0, d);
        check_value("V0", d, 32'd0);
        finish_test("reset and idle", start);
    endtask

    task automatic check_registers();
        int          start;
        logic [31:0] v;
        logic [31:0] d;
        start = errors;
        // run bit kept clear so the core stays parked
        v = $urandom & 32'hFFFF_FFFC;
        write_reg(REG_CTRL, v);
        read_reg(REG_CTRL, d);
        check_value("CTRL", d, v);
        write_reg(REG_STATUS, 32'hFFFF_FFFF);
        write_reg(REG_V0, 32'hFFFF_FFFF);
        write_reg(REG_RETIRED, 32'hFFFF_FFFF);
        read_reg(REG_STATUS, d);
        check_value("STATUS", d, 32'd1);
        read_reg(REG_V0, d);
        check_value("V0", d, 32'd0);
        read_reg(REG_RETIRED, d);
        check_value("RETIRED", d, 32'd0);
        read_reg(4'h2, d);
        check_value("unmapped rdata", d, 32'd0);
        write_reg(REG_CTRL, 32'd0);
        finish_test("register map", start);
    endtask

    task automatic check_arith();
        int          start;
        logic [31:0] prog[$];
        logic [15:0] a;
        logic [15:0] b;
        logic [31:0] opa;
        logic [31:0] opb;
        logic [31:0] exp;
        logic [31:0] d;
        start = errors;
        apply_reset();
        a = 16'($urandom);
        b = 16'($urandom);
        prog = {itype(OP_ADDIU, R_ZERO, R_T0, a),
                itype(OP_ADDIU, R_ZERO, R_T1, b),
                rtype(R_T0, R_T1, R_T2, FN_ADDU),
                rtype(R_T0, R_T1, R_T3, FN_SUBU),
                rtype(R_T2, R_T3, R_T4, FN_AND),
                rtype(R_T4, R_T1, R_T5, FN_OR),
                rtype(R_T5, R_T0, R_V0, FN_SUBU),
                JR_ZERO};
        // v0 = (((a + b) & (a - b)) | b) - a with a and b sign extended
        opa = sext(a);
        opb = sext(b);
        exp = (((opa + opb) & (opa - opb)) | opb) - opa;
        run_program(prog);
        check_value("register_v0", u_mips_subsys_top.register_v0, exp);
        read_reg(REG_V0, d);
        check_value("V0", d, exp);
        read_reg(REG_RETIRED, d);
        check_value("RETIRED", d, 32'd8);
        finish_test("arithmetic", start);
    endtask

    task automatic check_memory();
        int          start;
        int          stores_before;
        int          loads_before;
        logic [31:0] prog[$];
        logic [15:0] val;
        logic [31:0] d;
        start = errors;
        apply_reset();
        val = 16'($urandom);
        prog = {itype(OP_ADDIU, R_ZERO, R_T0, val),
                itype(OP_ADDIU, R_ZERO, R_T1, 16'h0040),
                itype(OP_SW, R_T1, R_T0, 16'h0008),
                itype(OP_LW, R_T1, R_V0, 16'h0008),
                JR_ZERO};
        // base 0x40 plus offset 8
        exp_store_addr = 32'h0000_0048;
        exp_store_data = sext(val);
        exp_load_addr  = 32'h0000_0048;
        stores_before  = stores;
        loads_before   = loads;
        run_program(prog);
        check_value("store count", 32'(stores - stores_before), 32'd1);
        check_value("load count", 32'(loads - loads_before), 32'd1);
        check_value("dmem word 0x48", dmem[18], sext(val));
        check_value("register_v0", u_mips_subsys_top.register_v0, sext(val));
        read_reg(REG_V0, d);
        check_value("V0", d, sext(val));
        read_reg(REG_RETIRED, d);
        check_value("RETIRED", d, 32'd5);
        finish_test("store and load", start);
    endtask

    task automatic check_branches();
        int          start;
        logic [31:0] prog[$];
        logic [31:0] d;
        start = errors;
        apply_reset();
        // word 3 is skipped by the taken beq and word 6 runs after the fall through
        prog = {itype(OP_ADDIU, R_ZERO, R_T0, 16'd5),
                itype(OP_ADDIU, R_ZERO, R_T1, 16'd5),
                itype(OP_BEQ, R_T0, R_T1, 16'd1),
                itype(OP_ADDIU, R_ZERO, R_V0, 16'h0111),
                itype(OP_ADDIU, R_ZERO, R_T2, 16'd7),
                itype(OP_BEQ, R_T0, R_T2, 16'd1),
                itype(OP_ADDIU, R_V0, R_V0, 16'h0022),
                JR_ZERO};
        run_program(prog);
        read_reg(REG_STATUS, d);
        check_value("STATUS", d, 32'd0);
        read_reg(REG_RETIRED, d);
        check_value("RETIRED", d, 32'd7);
        read_reg(REG_V0, d);
        check_value("V0", d, 32'h0000_0022);
        // pc parked on the jr word
        @(negedge clk);
        check_value("instr_address", instr_address, RESET_VECTOR + 32'd28);
        repeat (8) @(negedge clk);
        check_value("instr_address", instr_address, RESET_VECTOR + 32'd28);
        finish_test("branches and halt", start);
    endtask

    task automatic check_backpressure();
        int          start;
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] d_ctrl;
        logic [31:0] d_v0;
        start = errors;
        apply_reset();
        first  = $urandom & 32'hFFFF_FFFC;
        second = $urandom & 32'hFFFF_FFFC;
        // second write waits behind the stalled first response
        issue_write(REG_CTRL, first);
        fork
            issue_write(REG_CTRL, second);
            collect_bresp(4 + ($urandom % 8));
        join
        collect_bresp($urandom % 8);
        // reads go the same way and rdata has to hold while rready is low
        issue_read(REG_CTRL);
        fork
            issue_read(REG_V0);
            collect_rdata(4 + ($urandom % 8), d_ctrl);
        join
        collect_rdata($urandom % 8, d_v0);
        check_value("CTRL", d_ctrl, second);
        check_value("V0", d_v0, 32'd0);
        finish_test("back-pressure", start);
    endtask

    initial begin
        void'($urandom(32'h4662));
        rst_n          = 1'b0;
        axil_req       = '0;
        fresh          = 1'b1;
        exp_store_addr = '0;
        exp_store_data = '0;
        exp_load_addr  = '0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = JR_ZERO;
        end
        check_idle();
        check_registers();
        check_arith();
        check_memory();
        check_branches();
        check_backpressure();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* verilog/mips_subsys_top.sv */
`timescale 1ns/1ps

module mips_subsys_top (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::axil_req_t axil_req,
    output mips_pkg::axil_rsp_t axil_rsp,
    output logic [31:0]         instr_address,
    input  logic [31:0]         instr_readdata,
    output logic [31:0]         data_address,
    output logic                data_write,
    output logic                data_read,
    output logic [31:0]         data_writedata,
    input  logic [31:0]         data_readdata
);

    // core status into the register block
    logic        active;
    logic        retire;
    logic [31:0] register_v0;
    // run bit back to the core
    logic        run;

    mips_core u_core (
        .clk            (clk),
        .rst_n          (rst_n),
        .clk_enable     (run),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata),
        .active         (active),
        .retire         (retire),
        .register_v0    (register_v0)
    );

    mips_ctrl_regs u_ctrl_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .axil_req    (axil_req),
        .axil_rsp    (axil_rsp),
        .active      (active),
        .retire      (retire),
        .register_v0 (register_v0),
        .run         (run)
    );

endmodule

/* verilog/mips_ctrl_regs.sv */
`timescale 1ns/1ps

module mips_ctrl_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::axil_req_t axil_req,
    output mips_pkg::axil_rsp_t axil_rsp,
    input  logic                active,
    input  logic                retire,
    input  logic [31:0]         register_v0,
    output logic                run
);

    import mips_pkg::*;

    logic [31:0] ctrl_q;
    logic [31:0] retired_q;
    logic [31:0] rdata_q;
    logic [31:0] wmask;
    logic [31:0] rd_value;
    logic        bvalid_q;
    logic        rvalid_q;
    logic        wr_accept;
    logic        rd_accept;
    logic        ctrl_hit;
    logic        clear_hit;

    // address and data are taken together, blocked while a response waits
    assign wr_accept = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
    assign rd_accept = axil_req.arvalid && !rvalid_q;
    assign ctrl_hit  = wr_accept && (axil_req.awaddr == REG_CTRL);
    // bit 1 of a CTRL write zeroes the retired counter
    assign clear_hit = ctrl_hit && axil_req.wstrb[0] && axil_req.wdata[1];

    // byte lanes from wstrb
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            wmask[i*8 +: 8] = {8{axil_req.wstrb[i]}};
        end
    end

    // read mux, unmapped offsets give 0
    always_comb begin
        case (axil_req.araddr)
            REG_CTRL:    rd_value = ctrl_q;
            REG_STATUS:  rd_value = {31'd0, active};
            REG_V0:      rd_value = register_v0;
            REG_RETIRED: rd_value = retired_q;
            default:     rd_value = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q    <= '0;
            retired_q <= '0;
            bvalid_q  <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            if (ctrl_hit) begin
                ctrl_q <= (ctrl_q & ~wmask) | (axil_req.wdata & wmask);
            end
            if (clear_hit) begin
                retired_q <= '0;
            end else if (retire) begin
                retired_q <= retired_q + 32'd1;
            end
            // response valids hold until the manager takes them
            if (wr_accept) begin
                bvalid_q <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
            if (rd_accept) begin
                rvalid_q <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // read data captured on the arready edge
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata_q <= rd_value;
        end
    end

    always_comb begin
        axil_rsp         = '0;
        axil_rsp.awready = wr_accept;
        axil_rsp.wready  = wr_accept;
        axil_rsp.bvalid  = bvalid_q;
        // always OKAY
        axil_rsp.bresp   = 2'b00;
        axil_rsp.arready = rd_accept;
        axil_rsp.rvalid  = rvalid_q;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = 2'b00;
    end

    // run bit feeds the core clock enable
    assign run = ctrl_q[0];

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid);

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata));

endmodule

/* verilog/mips_core.sv */
`timescale 1ns/1ps

module mips_core (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clk_enable,
    output logic [31:0] instr_address,
    input  logic [31:0] instr_readdata,
    output logic [31:0] data_address,
    output logic        data_write,
    output logic        data_read,
    output logic [31:0] data_writedata,
    input  logic [31:0] data_readdata,
    output logic        active,
    output logic        retire,
    output logic [31:0] register_v0
);

    import mips_pkg::*;

    mips_instr_t instr;
    alu_op_t     alu_op;
    logic        alu_src_imm;
    logic        reg_dst_rd;
    logic        mem_to_reg;
    logic        reg_write;
    logic        mem_write;
    logic        mem_read;
    logic        branch_eq;
    logic        jump_reg;
    logic [31:0] pc;
    logic [31:0] pc_plus4;
    logic [31:0] imm_ext;
    logic [31:0] branch_target;
    logic [31:0] next_pc;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic [31:0] write_back;
    logic [4:0]  write_index;
    logic        alu_zero;
    logic        step;
    logic        halt;

    assign instr = instr_readdata;

    mips_decode u_decode (
        .instr       (instr),
        .alu_op      (alu_op),
        .alu_src_imm (alu_src_imm),
        .reg_dst_rd  (reg_dst_rd),
        .mem_to_reg  (mem_to_reg),
        .reg_write   (reg_write),
        .mem_write   (mem_write),
        .mem_read    (mem_read),
        .branch_eq   (branch_eq),
        .jump_reg    (jump_reg)
    );

    // rd for R-type and rt for addiu and lw
    assign write_index = reg_dst_rd ? instr.r.rd : instr.r.rt;
    // loads write back the memory word
    assign write_back  = mem_to_reg ? data_readdata : alu_result;

    mips_regfile u_regfile (
        .clk          (clk),
        .rst_n        (rst_n),
        .clk_enable   (clk_enable),
        .write_enable (reg_write && active),
        .read_index_a (instr.r.rs),
        .read_index_b (instr.r.rt),
        .write_index  (write_index),
        .write_data   (write_back),
        .read_data_a  (rs_data),
        .read_data_b  (rt_data),
        .register_v0  (register_v0)
    );

    // sign extension for addiu, lw, sw and the beq offset
    assign imm_ext = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign alu_b   = alu_src_imm ? imm_ext : rt_data;

    mips_alu u_alu (
        .op     (alu_op),
        .op_a   (rs_data),
        .op_b   (alu_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    assign pc_plus4      = pc + 32'd4;
    // no delay slot so the target is relative to the next word
    assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};

    always_comb begin
        if (jump_reg) begin
            next_pc = rs_data;
        end else if (branch_eq && alu_zero) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // one instruction per enabled cycle while running
    assign step = clk_enable && active;
    // jr to address 0 ends the program
    assign halt = jump_reg && (rs_data == 32'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= RESET_VECTOR;
            active <= 1'b1;
        end else if (step) begin
            if (halt) begin
                // pc stays on the jr word
                active <= 1'b0;
            end else begin
                pc <= next_pc;
            end
        end
    end

    assign instr_address  = pc;
    assign retire         = step;
    assign data_address   = alu_result;
    assign data_writedata = rt_data;
    // stores only land on a retiring edge
    assign data_write     = mem_write && step;
    assign data_read      = mem_read && active;

    a_rw_excl: assert property (@(posedge clk) disable iff (!rst_n) !(data_write && data_read));

endmodule

/* verilog/mips_decode.sv */
`timescale 1ns/1ps

module mips_decode (
    input  mips_pkg::mips_instr_t instr,
    output mips_pkg::alu_op_t     alu_op,
    output logic                  alu_src_imm,
    output logic                  reg_dst_rd,
    output logic                  mem_to_reg,
    output logic                  reg_write,
    output logic                  mem_write,
    output logic                  mem_read,
    output logic                  branch_eq,
    output logic                  jump_reg
);

    import mips_pkg::*;

    always_comb begin
        // unknown words fall through as a no-op
        alu_op      = ALU_ADD;
        alu_src_imm = 1'b0;
        reg_dst_rd  = 1'b0;
        mem_to_reg  = 1'b0;
        reg_write   = 1'b0;
        mem_write   = 1'b0;
        mem_read    = 1'b0;
        branch_eq   = 1'b0;
        jump_reg    = 1'b0;

        case (instr.r.opcode)
            OP_RTYPE: begin
                // funct picks the operation and rd is the destination
                reg_dst_rd = 1'b1;
                case (instr.r.funct)
                    FN_ADDU: begin
                        alu_op    = ALU_ADD;
                        reg_write = 1'b1;
                    end
                    FN_SUBU: begin
                        alu_op    = ALU_SUB;
                        reg_write = 1'b1;
                    end
                    FN_AND: begin
                        alu_op    = ALU_AND;
                        reg_write = 1'b1;
                    end
                    FN_OR: begin
                        alu_op    = ALU_OR;
                        reg_write = 1'b1;
                    end
                    // jr only redirects the pc
                    FN_JR:   jump_reg = 1'b1;
                    default: reg_dst_rd = 1'b0;
                endcase
            end
            OP_BEQ: begin
                alu_op    = ALU_SUB;
                branch_eq = 1'b1;
            end
            OP_ADDIU: begin
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
            end
            OP_LW: begin
                // rt gets the loaded word
                alu_src_imm = 1'b1;
                mem_to_reg  = 1'b1;
                reg_write   = 1'b1;
                mem_read    = 1'b1;
            end
            OP_SW: begin
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
            end
            default: alu_op = ALU_ADD;
        endcase
    end

endmodule

/* verilog/mips_alu.sv */
`timescale 1ns/1ps

module mips_alu (
    input  mips_pkg::alu_op_t op,
    input  logic [31:0]       op_a,
    input  logic [31:0]       op_b,
    output logic [31:0]       result,
    output logic              zero
);

    import mips_pkg::*;

    always_comb begin
        case (op)
            // addu, addiu and address generation
            ALU_ADD: result = op_a + op_b;
            // subu and the beq compare
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            default: result = '0;
        endcase
    end

    // beq is taken when rs - rt is zero
    assign zero = (result == 32'd0);

endmodule

/* verilog/mips_regfile.sv */
`timescale 1ns/1ps

module mips_regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clk_enable,
    input  logic        write_enable,
    input  logic [4:0]  read_index_a,
    input  logic [4:0]  read_index_b,
    input  logic [4:0]  write_index,
    input  logic [31:0] write_data,
    output logic [31:0] read_data_a,
    output logic [31:0] read_data_b,
    output logic [31:0] register_v0
);

    logic [31:0] regs [32];
    logic        do_write;

    // $zero is never a write target so it keeps its reset value
    assign do_write = clk_enable && write_enable && (write_index != 5'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (do_write) begin
            regs[write_index] <= write_data;
        end
    end

    // combinational read ports
    assign read_data_a = regs[read_index_a];
    assign read_data_b = regs[read_index_b];
    // v0 is register 2
    assign register_v0 = regs[2];

endmodule

/* verilog/mips_pkg.sv */
package mips_pkg;

    // R-type layout, register to register ops and jr
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } mips_rtype_t;

    // I-type layout, immediates, loads, stores and branches
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } mips_itype_t;

    // one instruction word seen through either layout
    typedef union packed {
        mips_rtype_t r;
        mips_itype_t i;
    } mips_instr_t;

    // primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'd0;
    localparam logic [5:0] OP_BEQ   = 6'd4;
    localparam logic [5:0] OP_ADDIU = 6'd9;
    localparam logic [5:0] OP_LW    = 6'd35;
    localparam logic [5:0] OP_SW    = 6'd43;

    // funct codes under OP_RTYPE
    localparam logic [5:0] FN_JR   = 6'd8;
    localparam logic [5:0] FN_ADDU = 6'd33;
    localparam logic [5:0] FN_SUBU = 6'd35;
    localparam logic [5:0] FN_AND  = 6'd36;
    localparam logic [5:0] FN_OR   = 6'd37;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR
    } alu_op_t;

    // first fetch address after reset
    localparam logic [31:0] RESET_VECTOR = 32'hBFC0_0000;

    // manager to subordinate side of the control port
    typedef struct packed {
        logic        awvalid;
        logic [3:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [3:0]  araddr;
        logic        rready;
    } axil_req_t;

    // subordinate to manager side
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    // control block register map
    localparam logic [3:0] REG_CTRL    = 4'h0;
    localparam logic [3:0] REG_STATUS  = 4'h4;
    localparam logic [3:0] REG_V0      = 4'h8;
    localparam logic [3:0] REG_RETIRED = 4'hC;

endpackage
